// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_multiface
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: common/mf2_consts.svh
`ifndef MF2_CONSTS_SVH
`define MF2_CONSTS_SVH

//////////////////////////////
// Widths and sizes
//////////////////////////////

`define MF2_ADDR_W 13
`define MF2_DATA_W 8
`define MF2_DEPTH 8192

// Page selects on cpu_addr[15:13]
`define MF2_ROM_PAGE 3'b000
`define MF2_RAM_PAGE 3'b001

//////////////////////////////
// CPU addresses
//////////////////////////////

`define MF2_NMI_VECTOR 16'h0066
`define MF2_HIDE_VECTOR 16'h0065
`define MF2_PAGE_PORT 14'b11111110111010   // 0xFEE8 and 0xFEEA

// Snooped I/O port high bytes
`define MF2_PORT_GA 8'h7F
`define MF2_PORT_CRTC_SEL 8'hBC
`define MF2_PORT_CRTC_DAT 8'hBD
`define MF2_PORT_PPI 8'hF7
`define MF2_PORT_ROM_SEL 8'hDF

//////////////////////////////
// Slots in cartridge RAM
//////////////////////////////

`define MF2_SLOT_PEN_INDEX 13'h1FCF
`define MF2_SLOT_PEN_BASE 13'h1F90     // Plus pen 0..15
`define MF2_SLOT_BORDER 13'h1FDF
`define MF2_SLOT_SCREEN_MODE 13'h1FEF
`define MF2_SLOT_BANKING 13'h1FFF
`define MF2_SLOT_CRTC_SEL 13'h1CFF
`define MF2_SLOT_CRTC_BASE 13'h1DB0    // Plus register 0..15
`define MF2_SLOT_PPI 13'h17FF
`define MF2_SLOT_UPPER_ROM 13'h1AAC

`define MF2_IDLE_BYTE 8'hFF

`endif

// File: common/mf2_pkg.sv
package mf2_pkg;

	//////////////////////////////
	// Cartridge configuration
	//////////////////////////////

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,     // Pages in on freeze
		MF2_HIDDEN   = 2'd1,     // Present but hidden after reset
		MF2_DISABLED = 2'd2      // Never pages in
	} mf2_mode_t;

	//////////////////////////////
	// Snooped register writes
	//////////////////////////////

	typedef enum logic [3:0] {
		ST_NONE         = 4'd0,
		ST_PEN_INDEX    = 4'd1,  // Gate array function 00
		ST_PEN_COLOR    = 4'd2,  // Gate array function 01, ink
		ST_BORDER_COLOR = 4'd3,  // Function 01 with pen bit 4 set
		ST_SCREEN_MODE  = 4'd4,  // Function 10
		ST_BANKING      = 4'd5,  // Function 11
		ST_CRTC_SELECT  = 4'd6,
		ST_CRTC_VALUE   = 4'd7,
		ST_PPI          = 4'd8,
		ST_UPPER_ROM    = 4'd9
	} mf2_store_t;

endpackage

// File: multiface/mf2_control.sv
`timescale 1ns/10ps
`include "mf2_consts.svh"

module mf2_control (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  mf2_pkg::mf2_mode_t     mf2_mode,
	input  logic [15:0]            cpu_addr,
	input  logic [`MF2_DATA_W-1:0] cpu_dout,
	input  logic                   mem_wr,
	input  logic                   mem_rd,
	input  logic                   m1,
	input  logic                   key_nmi,
	input  logic                   page_wr,
	input  logic                   page_out,
	input  logic                   store_wr,
	input  logic [`MF2_ADDR_W-1:0] store_addr,
	input  logic [`MF2_DATA_W-1:0] store_data,
	input  logic [`MF2_DATA_W-1:0] ram_dout,
	output logic                   nmi,
	output logic                   mf2_en,
	output logic                   mf2_rom_en,
	output logic                   mf2_ram_en,
	output logic [`MF2_ADDR_W-1:0] ram_addr,
	output logic                   ram_we,
	output logic [`MF2_DATA_W-1:0] ram_din,
	output logic [`MF2_DATA_W-1:0] mf2_dout
);
	import mf2_pkg::*;

	logic key_d;
	logic m1_d;
	logic key_rise;
	logic m1_rise;
	logic hidden;
	logic mode_off;
	logic cpu_ram_wr;
	logic rd_issue;   // CPU read owns the port this cycle
	logic rd_pend;
	logic rd_valid;

	assign key_rise   = key_nmi & ~key_d;
	assign m1_rise    = m1 & ~m1_d;
	assign mode_off   = (mf2_mode == MF2_DISABLED);
	assign mf2_rom_en = mf2_en & (cpu_addr[15:13] == `MF2_ROM_PAGE);
	assign mf2_ram_en = mf2_en & (cpu_addr[15:13] == `MF2_RAM_PAGE);
	assign cpu_ram_wr = mem_wr & mf2_ram_en;
	assign rd_issue   = mem_rd & mf2_ram_en & ~store_wr & ~cpu_ram_wr;

	//////////////////////////////
	// NMI, enable and hidden
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		key_d <= key_nmi;
		m1_d  <= m1;
		if (reset) begin
			nmi    <= 1'b0;
			mf2_en <= 1'b0;
			hidden <= (mf2_mode != MF2_ENABLED);
		end else begin
			if (key_rise & ~mf2_en & ~mode_off)
				nmi <= 1'b1;
			if (nmi & m1_rise & (cpu_addr == `MF2_NMI_VECTOR)) begin   // Freeze entry
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (mf2_en & m1_rise & (cpu_addr == `MF2_HIDE_VECTOR))
				hidden <= 1'b1;
			// Port write has the last word on the enable
			if (page_wr)
				mf2_en <= ~page_out & ~hidden & ~mode_off;
		end
	end

	//////////////////////////////
	// RAM port and read path
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_we   <= 1'b0;
			rd_pend  <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			ram_we   <= store_wr | cpu_ram_wr;
			rd_pend  <= rd_issue;
			rd_valid <= rd_pend;   // Lines up with ram_dout
		end
	end

	always_ff @(posedge clk_sys) begin
		if (store_wr) begin   // Snooped store first
			ram_addr <= store_addr;
			ram_din  <= store_data;
		end else begin
			ram_addr <= cpu_addr[`MF2_ADDR_W-1:0];
			ram_din  <= cpu_dout;
		end
	end

	assign mf2_dout = rd_valid ? ram_dout : `MF2_IDLE_BYTE;

endmodule

// File: multiface/mf2_ram.sv
`timescale 1ns/10ps
`include "mf2_consts.svh"

module mf2_ram (
	input  logic                   clk_sys,
	input  logic [`MF2_ADDR_W-1:0] ram_addr,
	input  logic                   ram_we,
	input  logic [`MF2_DATA_W-1:0] ram_din,
	output logic [`MF2_DATA_W-1:0] ram_dout
);

	//////////////////////////////
	// 8 KB cartridge RAM
	//////////////////////////////

	logic [`MF2_DATA_W-1:0] mem [`MF2_DEPTH];

	// Array write
	always_ff @(posedge clk_sys) begin
		if (ram_we)
			mem[ram_addr] <= ram_din;
	end

	// Output register
	// A write shows the new byte on the next cycle
	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram_dout <= ram_din;   // Write-through
		else
			ram_dout <= mem[ram_addr];
	end

endmodule

// File: multiface/mf2_snoop.sv
`timescale 1ns/10ps
`include "mf2_consts.svh"

module mf2_snoop (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [15:0]            cpu_addr,
	input  logic [`MF2_DATA_W-1:0] cpu_dout,
	input  logic                   io_wr,
	output logic                   page_wr,
	output logic                   page_out,
	output logic                   store_wr,
	output logic [`MF2_ADDR_W-1:0] store_addr,
	output logic [`MF2_DATA_W-1:0] store_data
);
	import mf2_pkg::*;

	logic                   io_wr_d;
	logic                   io_wr_rise;
	logic                   page_hit;
	mf2_store_t             kind;
	logic [4:0]             pen_index;   // Last pen selected on the gate array
	logic [3:0]             crtc_reg;    // Last CRTC register selected
	logic [`MF2_ADDR_W-1:0] slot_addr;

	assign io_wr_rise = io_wr & ~io_wr_d;
	assign page_hit   = (cpu_addr[15:2] == `MF2_PAGE_PORT);

	//////////////////////////////
	// Classify the write
	//////////////////////////////

	always_comb begin
		kind = ST_NONE;
		case (cpu_addr[15:8])
			`MF2_PORT_GA: begin
				case (cpu_dout[7:6])
					2'b00:   kind = ST_PEN_INDEX;
					2'b01:   kind = pen_index[4] ? ST_BORDER_COLOR : ST_PEN_COLOR;
					2'b10:   kind = ST_SCREEN_MODE;
					default: kind = ST_BANKING;
				endcase
			end
			`MF2_PORT_CRTC_SEL: kind = ST_CRTC_SELECT;
			`MF2_PORT_CRTC_DAT: kind = ST_CRTC_VALUE;
			`MF2_PORT_PPI:      kind = ST_PPI;
			`MF2_PORT_ROM_SEL:  kind = ST_UPPER_ROM;
			default:            kind = ST_NONE;
		endcase
	end

	// Slot address from the kind
	always_comb begin
		case (kind)
			ST_PEN_INDEX:    slot_addr = `MF2_SLOT_PEN_INDEX;
			ST_PEN_COLOR:    slot_addr = `MF2_SLOT_PEN_BASE |
				{{(`MF2_ADDR_W-4){1'b0}}, pen_index[3:0]};
			ST_BORDER_COLOR: slot_addr = `MF2_SLOT_BORDER;
			ST_SCREEN_MODE:  slot_addr = `MF2_SLOT_SCREEN_MODE;
			ST_BANKING:      slot_addr = `MF2_SLOT_BANKING;
			ST_CRTC_SELECT:  slot_addr = `MF2_SLOT_CRTC_SEL;
			ST_CRTC_VALUE:   slot_addr = `MF2_SLOT_CRTC_BASE |
				{{(`MF2_ADDR_W-4){1'b0}}, crtc_reg};
			ST_PPI:          slot_addr = `MF2_SLOT_PPI;
			ST_UPPER_ROM:    slot_addr = `MF2_SLOT_UPPER_ROM;
			default:         slot_addr = '0;
		endcase
	end

	//////////////////////////////
	// Strobes and tracking
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		io_wr_d <= io_wr;   // Previous level for the edge detect
		if (reset) begin
			page_wr   <= 1'b0;
			store_wr  <= 1'b0;
			pen_index <= '0;
			crtc_reg  <= '0;
		end else begin
			page_wr  <= io_wr_rise & page_hit;   // Paging wins over a store
			store_wr <= io_wr_rise & ~page_hit & (kind != ST_NONE);
			if (io_wr_rise & ~page_hit) begin
				if (kind == ST_PEN_INDEX)
					pen_index <= cpu_dout[4:0];
				if (kind == ST_CRTC_SELECT)
					crtc_reg <= cpu_dout[3:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			page_out   <= cpu_addr[1];   // FEEA pages out
			store_addr <= slot_addr;
			store_data <= cpu_dout;
		end
	end

endmodule

// File: multiface/multiface_top.sv
`timescale 1ns/10ps
`include "mf2_consts.svh"

module multiface_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [15:0]            cpu_addr,
	input  logic [`MF2_DATA_W-1:0] cpu_dout,
	input  logic                   io_wr,
	input  logic                   mem_wr,
	input  logic                   mem_rd,
	input  logic                   m1,
	input  logic                   key_nmi,
	input  mf2_pkg::mf2_mode_t     mf2_mode,
	output logic                   nmi,
	output logic                   mf2_en,
	output logic                   mf2_rom_en,
	output logic                   mf2_ram_en,
	output logic [`MF2_DATA_W-1:0] mf2_dout
);

	// Snoop to control
	logic                   page_wr;
	logic                   page_out;
	logic                   store_wr;
	logic [`MF2_ADDR_W-1:0] store_addr;
	logic [`MF2_DATA_W-1:0] store_data;

	// Control to RAM
	logic [`MF2_ADDR_W-1:0] ram_addr;
	logic                   ram_we;
	logic [`MF2_DATA_W-1:0] ram_din;
	logic [`MF2_DATA_W-1:0] ram_dout;

	mf2_snoop i_snoop (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.io_wr      (io_wr),
		.page_wr    (page_wr),
		.page_out   (page_out),
		.store_wr   (store_wr),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	mf2_ram i_ram (
		.clk_sys  (clk_sys),
		.ram_addr (ram_addr),
		.ram_we   (ram_we),
		.ram_din  (ram_din),
		.ram_dout (ram_dout)
	);

	mf2_control i_control (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mf2_mode   (mf2_mode),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.m1         (m1),
		.key_nmi    (key_nmi),
		.page_wr    (page_wr),
		.page_out   (page_out),
		.store_wr   (store_wr),
		.store_addr (store_addr),
		.store_data (store_data),
		.ram_dout   (ram_dout),
		.nmi        (nmi),
		.mf2_en     (mf2_en),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.ram_addr   (ram_addr),
		.ram_we     (ram_we),
		.ram_din    (ram_din),
		.mf2_dout   (mf2_dout)
	);

endmodule

// File: project.f
+incdir+common
common/mf2_pkg.sv
multiface/mf2_snoop.sv
multiface/mf2_ram.sv
multiface/mf2_control.sv
multiface/multiface_top.sv
testbench/mf2_props.sv
testbench/tb_multiface.sv

// File: testbench/mf2_props.sv
`timescale 1ns/10ps
`include "mf2_consts.svh"

module mf2_props (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   mem_rd,
	input logic                   nmi,
	input logic                   mf2_en,
	input logic                   ram_we,
	input logic [`MF2_DATA_W-1:0] mf2_dout
);

	//////////////////////////////
	// Reset behavior
	//////////////////////////////

	a_reset_idle: assert property (@(posedge clk_sys) $fell(reset) |-> (!nmi && !mf2_en))
		else $error("nmi or mf2_en high in the first cycle after reset");

	a_no_write_in_reset: assert property (@(posedge clk_sys) (reset && $past(reset)) |-> !ram_we)
		else $error("RAM write while in reset");

	//////////////////////////////
	// Read path
	//////////////////////////////

	a_idle_dout: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(mem_rd, 2) |-> (mf2_dout == `MF2_IDLE_BYTE))   // Two-cycle read latency
		else $error("mf2_dout driven without a read two cycles earlier");

endmodule

bind multiface_top mf2_props i_props (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.mem_rd     (mem_rd),
	.nmi        (nmi),
	.mf2_en     (mf2_en),
	.ram_we     (ram_we),
	.mf2_dout   (mf2_dout)
);

// File: testbench/tb_multiface.sv
`timescale 1ns/10ps
`include "mf2_consts.svh"

module tb_multiface;
	import mf2_pkg::*;

	localparam int          TIMEOUT_CYCLES = 64;
	localparam int          SEL_NMI        = 0;
	localparam int          SEL_EN         = 1;
	localparam logic [15:0] IDLE_ADDR      = 16'hC000;   // Outside both cartridge windows

	logic                   clk_sys;
	logic                   reset;
	logic [15:0]            cpu_addr;
	logic [`MF2_DATA_W-1:0] cpu_dout;
	logic                   io_wr;
	logic                   mem_wr;
	logic                   mem_rd;
	logic                   m1;
	logic                   key_nmi;
	mf2_mode_t              mf2_mode;
	logic                   nmi;
	logic                   mf2_en;
	logic                   mf2_rom_en;
	logic                   mf2_ram_en;
	logic [`MF2_DATA_W-1:0] mf2_dout;

	logic [31:0] lcg_state;
	int          error_count;

	multiface_top i_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.io_wr      (io_wr),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.m1         (m1),
		.key_nmi    (key_nmi),
		.mf2_mode   (mf2_mode),
		.nmi        (nmi),
		.mf2_en     (mf2_en),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.mf2_dout   (mf2_dout)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;   // 40 ns period

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_on_error(input string line);
		error_count++;
		$display("%s", line);
		$display("sim failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED at %0t ns: %s is 0x%02h, expected 0x%02h",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	function automatic logic watched(input int sel);
		return (sel == SEL_NMI) ? nmi : mf2_en;
	endfunction

	// Poll once per cycle until the level shows up
	task automatic wait_for_level(input string what, input int sel, input logic level);
		int n;
		n = 0;
		@(posedge clk_sys);
		#1;
		while (watched(sel) !== level) begin
			if (n == TIMEOUT_CYCLES)
				stop_on_error($sformatf("Timeout at %0t ns: %s never went to %b",
					$time, what, level));
			n++;
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic check_stays(input string what, input int sel, input logic level);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			#1;
			check_bit(what, watched(sel), level);
		end
	endtask

	//////////////////////////////
	// Bus cycles
	//////////////////////////////

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		#2;
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = 1'b1;
		@(posedge clk_sys);
		#2;
		io_wr    = 1'b0;
		cpu_addr = IDLE_ADDR;
		repeat (2) @(posedge clk_sys);   // Stored value lands in RAM by now
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		#2;
		cpu_addr = addr;
		cpu_dout = data;
		mem_wr   = 1'b1;
		@(posedge clk_sys);
		#2;
		mem_wr   = 1'b0;
		cpu_addr = IDLE_ADDR;
	endtask

	// Address and mem_rd held 3 cycles, byte sampled in the last
	task automatic read_byte(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk_sys);
		#2;
		cpu_addr = addr;
		mem_rd   = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		data = mf2_dout;
		@(posedge clk_sys);
		#2;
		mem_rd   = 1'b0;
		cpu_addr = IDLE_ADDR;
	endtask

	task automatic read_expect(input string what, input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		read_byte(addr, got);
		check_byte($sformatf("%s at 0x%04h", what, addr), got, exp);
	endtask

	task automatic fetch_opcode(input logic [15:0] addr);
		@(posedge clk_sys);
		#2;
		cpu_addr = addr;
		m1       = 1'b1;
		@(posedge clk_sys);
		#2;
		m1       = 1'b0;
		cpu_addr = IDLE_ADDR;
	endtask

	task automatic drive_key(input logic level);
		@(posedge clk_sys);
		#2;
		key_nmi = level;
	endtask

	task automatic drive_mode(input mf2_mode_t mode);
		@(posedge clk_sys);
		#2;
		mf2_mode = mode;
	endtask

	task automatic probe_windows(input logic [15:0] addr, input logic rom_exp, input logic ram_exp);
		@(posedge clk_sys);
		#2;
		cpu_addr = addr;
		#1;
		check_bit($sformatf("mf2_rom_en at 0x%04h", addr), mf2_rom_en, rom_exp);
		check_bit($sformatf("mf2_ram_en at 0x%04h", addr), mf2_ram_en, ram_exp);
		cpu_addr = IDLE_ADDR;
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_after_reset();
		@(posedge clk_sys);
		#1;
		check_bit("nmi after reset", nmi, 1'b0);
		check_bit("mf2_en after reset", mf2_en, 1'b0);
		read_expect("paged-out read", 16'h2000, 8'hFF);
	endtask

	task automatic test_freeze();
		drive_mode(MF2_DISABLED);
		drive_key(1'b1);
		check_stays("nmi with cartridge disabled", SEL_NMI, 1'b0);
		drive_key(1'b0);
		drive_mode(MF2_ENABLED);
		drive_key(1'b1);
		wait_for_level("nmi after key press", SEL_NMI, 1'b1);
		fetch_opcode(16'h0066);   // NMI vector fetch pages in
		wait_for_level("mf2_en after NMI fetch", SEL_EN, 1'b1);
		check_bit("nmi after NMI fetch", nmi, 1'b0);
		drive_key(1'b0);
		probe_windows(16'h0100, 1'b1, 1'b0);
		probe_windows(16'h2100, 1'b0, 1'b1);
	endtask

	task automatic test_snoop();
		logic [31:0] r;
		logic [3:0]  crtc_n;
		logic [7:0]  crtc_v;
		logic [3:0]  pen;
		logic [7:0]  ink;
		logic [7:0]  border;
		logic [7:0]  ppi;
		logic [7:0]  rom_sel;
		r       = lcg_next();
		crtc_n  = r[19:16];
		crtc_v  = r[31:24];
		r       = lcg_next();
		pen     = r[11:8];
		ink     = {2'b01, r[29:24]};
		border  = {2'b01, r[21:16]};
		r       = lcg_next();
		ppi     = r[31:24];
		rom_sel = r[23:16];
		io_write(16'hBC00, {4'h0, crtc_n});
		io_write(16'hBD00, crtc_v);
		read_expect("CRTC select slot", 16'h3CFF, {4'h0, crtc_n});
		read_expect("CRTC value slot", 16'h3DB0 + {12'h0, crtc_n}, crtc_v);
		io_write(16'h7F00, {4'h0, pen});   // Function 00, pen bit 4 clear
		io_write(16'h7F00, ink);
		read_expect("pen index slot", 16'h3FCF, {4'h0, pen});
		read_expect("pen color slot", 16'h3F90 + {12'h0, pen}, ink);
		io_write(16'h7F00, 8'h10);   // Pen 16 means border
		io_write(16'h7F00, border);
		read_expect("border slot", 16'h3FDF, border);
		io_write(16'hF700, ppi);
		read_expect("PPI slot", 16'h37FF, ppi);
		io_write(16'hDF00, rom_sel);
		read_expect("upper ROM slot", 16'h3AAC, rom_sel);
	endtask

	task automatic test_ram();
		logic [15:0] addrs [16];
		logic [7:0]  model [logic [15:0]];
		logic [31:0] r;
		logic [7:0]  d;
		for (int i = 0; i < 16; i++) begin
			r        = lcg_next();
			addrs[i] = 16'h2000 + (r[31:16] % 16'h1C00);
			d        = r[15:8];
			model[addrs[i]] = d;
			mem_write(addrs[i], d);
			read_expect("RAM byte", addrs[i], d);
		end
		// Second pass, later writes win on a repeated address
		for (int i = 0; i < 16; i++)
			read_expect("RAM byte on second pass", addrs[i], model[addrs[i]]);
	endtask

	task automatic test_paging();
		io_write(16'hFEEA, 8'h00);
		wait_for_level("mf2_en after FEEA write", SEL_EN, 1'b0);
		io_write(16'hFEE8, 8'h00);
		wait_for_level("mf2_en after FEE8 write", SEL_EN, 1'b1);
		fetch_opcode(16'h0065);   // Hides the cartridge
		io_write(16'hFEEA, 8'h00);
		wait_for_level("mf2_en after FEEA write when hidden", SEL_EN, 1'b0);
		io_write(16'hFEE8, 8'h00);
		check_stays("mf2_en after FEE8 write when hidden", SEL_EN, 1'b0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		lcg_state   = 32'h4bd9e371;
		error_count = 0;
		reset       = 1'b1;
		cpu_addr    = IDLE_ADDR;
		cpu_dout    = '0;
		io_wr       = 1'b0;
		mem_wr      = 1'b0;
		mem_rd      = 1'b0;
		m1          = 1'b0;
		key_nmi     = 1'b0;
		mf2_mode    = MF2_ENABLED;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		test_after_reset();
		test_freeze();
		test_snoop();
		test_ram();
		test_paging();
		repeat (4) @(posedge clk_sys);
		if (error_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "Errors were reported");
		end
	end

endmodule
